// ==== logic/axi_mem_pkg.sv ====
`default_nettype none

package axi_mem_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // sram window, 4 KiB
  localparam logic [addr_w-1:0] mem_base = 32'h8000_0000;
  localparam int mem_words = 1024;
  localparam int idx_w = 10;  // log2 of mem_words

  localparam int wait_w = 4;

  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2,  // reserved
    resp_decerr = 2'd3
  } axi_resp_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_wait,
    rd_resp
  } sram_rd_state_e;

  typedef enum logic [1:0] {
    wr_idle,
    wr_wait,
    wr_resp
  } sram_wr_state_e;

  typedef enum logic {
    cfg_rd_wait = 1'b0,
    cfg_wr_wait = 1'b1
  } cfg_reg_e;

endpackage

`default_nettype wire

// ==== logic/mem_wait_cfg.sv ====
`default_nettype none

module mem_wait_cfg (
  input  wire                           aclk,
  input  wire                           areset,
  input  wire                           cfg_wr,
  input  wire axi_mem_pkg::cfg_reg_e    cfg_sel,
  input  wire [axi_mem_pkg::wait_w-1:0] cfg_wdata,
  output logic [axi_mem_pkg::wait_w-1:0] rd_wait_cycles,
  output logic [axi_mem_pkg::wait_w-1:0] wr_wait_cycles
);

  import axi_mem_pkg::*;

  // zero waits out of reset, fastest slave timing
  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_wait_cycles <= '0;
      wr_wait_cycles <= '0;
    end else if (cfg_wr) begin
      case (cfg_sel)
        cfg_rd_wait: rd_wait_cycles <= cfg_wdata;
        cfg_wr_wait: wr_wait_cycles <= cfg_wdata;
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/sram_array.sv ====
`default_nettype none

module sram_array (
  input  wire                           aclk,
  input  wire                           rd_en,
  input  wire                           wr_en,
  input  wire [axi_mem_pkg::idx_w-1:0]  index,
  input  wire [axi_mem_pkg::data_w-1:0] wdata,
  input  wire [axi_mem_pkg::strb_w-1:0] strb,
  output logic [axi_mem_pkg::data_w-1:0] rdata
);

  import axi_mem_pkg::*;

  logic [data_w-1:0] mem [mem_words];

  // byte lanes written only where strobe set
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      for (int b = 0; b < strb_w; b++) begin
        if (strb[b]) begin
          mem[index][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // rdata holds until next rd_en
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

// ==== logic/axi_sram.sv ====
`default_nettype none

module axi_sram (
  input  wire                             aclk,
  input  wire                             areset,
  input  wire [axi_mem_pkg::addr_w-1:0]   araddr,
  input  wire                             arvalid,
  output logic                            arready,
  output logic [axi_mem_pkg::data_w-1:0]  rdata,
  output axi_mem_pkg::axi_resp_e          rresp,
  output logic                            rvalid,
  input  wire                             rready,
  input  wire [axi_mem_pkg::addr_w-1:0]   awaddr,
  input  wire                             awvalid,
  output logic                            awready,
  input  wire [axi_mem_pkg::data_w-1:0]   wdata,
  input  wire [axi_mem_pkg::strb_w-1:0]   wstrb,
  input  wire                             wvalid,
  output logic                            wready,
  output axi_mem_pkg::axi_resp_e          bresp,
  output logic                            bvalid,
  input  wire                             bready,
  input  wire [axi_mem_pkg::wait_w-1:0]   rd_wait_cycles,
  input  wire [axi_mem_pkg::wait_w-1:0]   wr_wait_cycles,
  output logic                            mem_rd_en,
  output logic                            mem_wr_en,
  output logic [axi_mem_pkg::idx_w-1:0]   mem_index,
  output logic [axi_mem_pkg::data_w-1:0]  mem_wdata,
  output logic [axi_mem_pkg::strb_w-1:0]  mem_strb,
  input  wire [axi_mem_pkg::data_w-1:0]   mem_rdata
);

  import axi_mem_pkg::*;

  sram_rd_state_e    rd_state;
  sram_wr_state_e    wr_state;
  logic [wait_w-1:0] rd_cnt;
  logic [wait_w-1:0] wr_cnt;
  logic              rd_access;  // array read still to issue
  logic              rd_oob;
  logic [idx_w-1:0]  rd_idx;
  logic              rd_finish;
  logic              aw_held;
  logic              w_held;
  logic              aw_done;
  logic              w_done;
  logic              wr_pend;    // array write still to issue
  logic              wr_oob;
  logic [idx_w-1:0]  wr_idx;
  logic [data_w-1:0] wdata_q;
  logic [strb_w-1:0] wstrb_q;
  logic              wr_go;
  logic              wr_finish;

  function automatic logic in_window(input logic [addr_w-1:0] addr);
    logic [addr_w-1:0] offset;
    offset = addr - mem_base;
    return (addr >= mem_base) && (offset[addr_w-1:idx_w+2] == '0);
  endfunction

  function automatic logic [idx_w-1:0] word_index(input logic [addr_w-1:0] addr);
    logic [addr_w-1:0] offset;
    offset = addr - mem_base;
    return offset[idx_w+1:2];
  endfunction

  // single port, reads win over a pending write
  assign mem_rd_en = (rd_state == rd_wait) && rd_access && !rd_oob;
  assign wr_go     = wr_pend && !mem_rd_en;
  assign mem_wr_en = wr_go && !wr_oob;
  assign mem_index = mem_rd_en ? rd_idx : wr_idx;
  assign mem_wdata = wdata_q;
  assign mem_strb  = wstrb_q;

  assign rd_finish = (rd_state == rd_wait) && !rd_access && (rd_cnt == '0);
  assign wr_finish = (wr_state == wr_wait) && (wr_go || !wr_pend) && (wr_cnt == '0);

  assign aw_done = aw_held || (awvalid && awready);
  assign w_done  = w_held || (wvalid && wready);

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_state  <= rd_idle;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      rd_access <= 1'b0;
      rd_cnt    <= '0;
    end else begin
      case (rd_state)
        rd_idle: begin
          arready <= 1'b1;
          if (arvalid && arready) begin
            rd_state  <= rd_wait;
            arready   <= 1'b0;
            rd_access <= 1'b1;
            rd_cnt    <= rd_wait_cycles;  // sampled at accept
          end
        end
        rd_wait: begin
          rd_access <= 1'b0;
          if (rd_finish) begin
            rd_state <= rd_resp;
            rvalid   <= 1'b1;
          end else if (!rd_access) begin
            rd_cnt <= rd_cnt - 1'b1;
          end
        end
        rd_resp: begin
          if (rready) begin
            rd_state <= rd_idle;
            rvalid   <= 1'b0;
            arready  <= 1'b1;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  // aw and w may arrive in either order
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_state <= wr_idle;
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      wr_pend  <= 1'b0;
      wr_cnt   <= '0;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (aw_done && w_done) begin
            wr_state <= wr_wait;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            wr_pend  <= 1'b1;
            wr_cnt   <= wr_wait_cycles;
          end else begin
            aw_held <= aw_done;
            w_held  <= w_done;
            awready <= !aw_done;
            wready  <= !w_done;
          end
        end
        wr_wait: begin
          if (wr_go) begin
            wr_pend <= 1'b0;
          end
          if (wr_finish) begin
            wr_state <= wr_resp;
            bvalid   <= 1'b1;
          end else if (wr_cnt != '0) begin
            wr_cnt <= wr_cnt - 1'b1;
          end
        end
        wr_resp: begin
          if (bready) begin
            wr_state <= wr_idle;
            bvalid   <= 1'b0;
            awready  <= 1'b1;
            wready   <= 1'b1;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (arvalid && arready) begin
      rd_idx <= word_index(araddr);
      rd_oob <= !in_window(araddr);
    end
    if (rd_finish) begin
      rdata <= rd_oob ? '0 : mem_rdata;
      rresp <= rd_oob ? resp_decerr : resp_okay;
    end
    if (awvalid && awready) begin
      wr_idx <= word_index(awaddr);
      wr_oob <= !in_window(awaddr);
    end
    if (wvalid && wready) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (wr_finish) begin
      bresp <= wr_oob ? resp_decerr : resp_okay;
    end
  end

endmodule

`default_nettype wire

// ==== logic/axi_read_arbiter.sv ====
`default_nettype none

module axi_read_arbiter (
  input  wire                             aclk,
  input  wire                             areset,
  // fetch master, read only
  input  wire [axi_mem_pkg::addr_w-1:0]   if_araddr,
  input  wire                             if_arvalid,
  output logic                            if_arready,
  output logic [axi_mem_pkg::data_w-1:0]  if_rdata,
  output axi_mem_pkg::axi_resp_e          if_rresp,
  output logic                            if_rvalid,
  input  wire                             if_rready,
  // load/store master
  input  wire [axi_mem_pkg::addr_w-1:0]   ls_araddr,
  input  wire                             ls_arvalid,
  output logic                            ls_arready,
  output logic [axi_mem_pkg::data_w-1:0]  ls_rdata,
  output axi_mem_pkg::axi_resp_e          ls_rresp,
  output logic                            ls_rvalid,
  input  wire                             ls_rready,
  input  wire [axi_mem_pkg::addr_w-1:0]   ls_awaddr,
  input  wire                             ls_awvalid,
  output logic                            ls_awready,
  input  wire [axi_mem_pkg::data_w-1:0]   ls_wdata,
  input  wire [axi_mem_pkg::strb_w-1:0]   ls_wstrb,
  input  wire                             ls_wvalid,
  output logic                            ls_wready,
  output axi_mem_pkg::axi_resp_e          ls_bresp,
  output logic                            ls_bvalid,
  input  wire                             ls_bready,
  // toward the slave
  output logic [axi_mem_pkg::addr_w-1:0]  s_araddr,
  output logic                            s_arvalid,
  input  wire                             s_arready,
  input  wire [axi_mem_pkg::data_w-1:0]   s_rdata,
  input  wire axi_mem_pkg::axi_resp_e     s_rresp,
  input  wire                             s_rvalid,
  output logic                            s_rready,
  output logic [axi_mem_pkg::addr_w-1:0]  s_awaddr,
  output logic                            s_awvalid,
  input  wire                             s_awready,
  output logic [axi_mem_pkg::data_w-1:0]  s_wdata,
  output logic [axi_mem_pkg::strb_w-1:0]  s_wstrb,
  output logic                            s_wvalid,
  input  wire                             s_wready,
  input  wire axi_mem_pkg::axi_resp_e     s_bresp,
  input  wire                             s_bvalid,
  output logic                            s_bready
);

  logic busy;     // read outstanding
  logic owner;    // 1 = load/store holds the r channel
  logic prio_ls;  // 0 = fetch wins a tie
  logic grant_ls;

  assign grant_ls = ls_arvalid && (!if_arvalid || prio_ls);

  assign s_arvalid  = !busy && (if_arvalid || ls_arvalid);
  assign s_araddr   = grant_ls ? ls_araddr : if_araddr;
  assign if_arready = !busy && !grant_ls && s_arready;
  assign ls_arready = !busy && grant_ls && s_arready;

  // r goes back only to the recorded owner
  assign if_rvalid = busy && !owner && s_rvalid;
  assign ls_rvalid = busy && owner && s_rvalid;
  assign s_rready  = busy && (owner ? ls_rready : if_rready);
  assign if_rdata  = s_rdata;
  assign ls_rdata  = s_rdata;
  assign if_rresp  = s_rresp;
  assign ls_rresp  = s_rresp;

  always_ff @(posedge aclk) begin
    if (areset) begin
      busy    <= 1'b0;
      owner   <= 1'b0;
      prio_ls <= 1'b0;
    end else if (!busy) begin
      if (s_arvalid && s_arready) begin
        busy    <= 1'b1;
        owner   <= grant_ls;
        prio_ls <= !grant_ls;  // other master first next time
      end
    end else if (s_rvalid && s_rready) begin
      busy <= 1'b0;
    end
  end

  // only load/store writes
  assign s_awaddr   = ls_awaddr;
  assign s_awvalid  = ls_awvalid;
  assign ls_awready = s_awready;
  assign s_wdata    = ls_wdata;
  assign s_wstrb    = ls_wstrb;
  assign s_wvalid   = ls_wvalid;
  assign ls_wready  = s_wready;
  assign ls_bresp   = s_bresp;
  assign ls_bvalid  = s_bvalid;
  assign s_bready   = ls_bready;

endmodule

`default_nettype wire

// ==== logic/axi_mem_top.sv ====
`default_nettype none

module axi_mem_top (
  input  wire                             aclk,
  input  wire                             areset,
  input  wire [axi_mem_pkg::addr_w-1:0]   if_araddr,
  input  wire                             if_arvalid,
  output logic                            if_arready,
  output logic [axi_mem_pkg::data_w-1:0]  if_rdata,
  output axi_mem_pkg::axi_resp_e          if_rresp,
  output logic                            if_rvalid,
  input  wire                             if_rready,
  input  wire [axi_mem_pkg::addr_w-1:0]   ls_araddr,
  input  wire                             ls_arvalid,
  output logic                            ls_arready,
  output logic [axi_mem_pkg::data_w-1:0]  ls_rdata,
  output axi_mem_pkg::axi_resp_e          ls_rresp,
  output logic                            ls_rvalid,
  input  wire                             ls_rready,
  input  wire [axi_mem_pkg::addr_w-1:0]   ls_awaddr,
  input  wire                             ls_awvalid,
  output logic                            ls_awready,
  input  wire [axi_mem_pkg::data_w-1:0]   ls_wdata,
  input  wire [axi_mem_pkg::strb_w-1:0]   ls_wstrb,
  input  wire                             ls_wvalid,
  output logic                            ls_wready,
  output axi_mem_pkg::axi_resp_e          ls_bresp,
  output logic                            ls_bvalid,
  input  wire                             ls_bready,
  input  wire                             cfg_wr,
  input  wire axi_mem_pkg::cfg_reg_e      cfg_sel,
  input  wire [axi_mem_pkg::wait_w-1:0]   cfg_wdata
);

  import axi_mem_pkg::*;

  // arbiter to slave
  logic [addr_w-1:0] s_araddr;
  logic              s_arvalid;
  logic              s_arready;
  logic [data_w-1:0] s_rdata;
  axi_resp_e         s_rresp;
  logic              s_rvalid;
  logic              s_rready;
  logic [addr_w-1:0] s_awaddr;
  logic              s_awvalid;
  logic              s_awready;
  logic [data_w-1:0] s_wdata;
  logic [strb_w-1:0] s_wstrb;
  logic              s_wvalid;
  logic              s_wready;
  axi_resp_e         s_bresp;
  logic              s_bvalid;
  logic              s_bready;

  logic [wait_w-1:0] rd_wait_cycles;
  logic [wait_w-1:0] wr_wait_cycles;

  // slave to array
  logic              mem_rd_en;
  logic              mem_wr_en;
  logic [idx_w-1:0]  mem_index;
  logic [data_w-1:0] mem_wdata;
  logic [strb_w-1:0] mem_strb;
  logic [data_w-1:0] mem_rdata;

  axi_read_arbiter i_arbiter (
    .aclk       (aclk),
    .areset     (areset),
    .if_araddr  (if_araddr),
    .if_arvalid (if_arvalid),
    .if_arready (if_arready),
    .if_rdata   (if_rdata),
    .if_rresp   (if_rresp),
    .if_rvalid  (if_rvalid),
    .if_rready  (if_rready),
    .ls_araddr  (ls_araddr),
    .ls_arvalid (ls_arvalid),
    .ls_arready (ls_arready),
    .ls_rdata   (ls_rdata),
    .ls_rresp   (ls_rresp),
    .ls_rvalid  (ls_rvalid),
    .ls_rready  (ls_rready),
    .ls_awaddr  (ls_awaddr),
    .ls_awvalid (ls_awvalid),
    .ls_awready (ls_awready),
    .ls_wdata   (ls_wdata),
    .ls_wstrb   (ls_wstrb),
    .ls_wvalid  (ls_wvalid),
    .ls_wready  (ls_wready),
    .ls_bresp   (ls_bresp),
    .ls_bvalid  (ls_bvalid),
    .ls_bready  (ls_bready),
    .s_araddr   (s_araddr),
    .s_arvalid  (s_arvalid),
    .s_arready  (s_arready),
    .s_rdata    (s_rdata),
    .s_rresp    (s_rresp),
    .s_rvalid   (s_rvalid),
    .s_rready   (s_rready),
    .s_awaddr   (s_awaddr),
    .s_awvalid  (s_awvalid),
    .s_awready  (s_awready),
    .s_wdata    (s_wdata),
    .s_wstrb    (s_wstrb),
    .s_wvalid   (s_wvalid),
    .s_wready   (s_wready),
    .s_bresp    (s_bresp),
    .s_bvalid   (s_bvalid),
    .s_bready   (s_bready)
  );

  axi_sram i_sram (
    .aclk           (aclk),
    .areset         (areset),
    .araddr         (s_araddr),
    .arvalid        (s_arvalid),
    .arready        (s_arready),
    .rdata          (s_rdata),
    .rresp          (s_rresp),
    .rvalid         (s_rvalid),
    .rready         (s_rready),
    .awaddr         (s_awaddr),
    .awvalid        (s_awvalid),
    .awready        (s_awready),
    .wdata          (s_wdata),
    .wstrb          (s_wstrb),
    .wvalid         (s_wvalid),
    .wready         (s_wready),
    .bresp          (s_bresp),
    .bvalid         (s_bvalid),
    .bready         (s_bready),
    .rd_wait_cycles (rd_wait_cycles),
    .wr_wait_cycles (wr_wait_cycles),
    .mem_rd_en      (mem_rd_en),
    .mem_wr_en      (mem_wr_en),
    .mem_index      (mem_index),
    .mem_wdata      (mem_wdata),
    .mem_strb       (mem_strb),
    .mem_rdata      (mem_rdata)
  );

  sram_array i_array (
    .aclk  (aclk),
    .rd_en (mem_rd_en),
    .wr_en (mem_wr_en),
    .index (mem_index),
    .wdata (mem_wdata),
    .strb  (mem_strb),
    .rdata (mem_rdata)
  );

  mem_wait_cfg i_wait_cfg (
    .aclk           (aclk),
    .areset         (areset),
    .cfg_wr         (cfg_wr),
    .cfg_sel        (cfg_sel),
    .cfg_wdata      (cfg_wdata),
    .rd_wait_cycles (rd_wait_cycles),
    .wr_wait_cycles (wr_wait_cycles)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic aclk,
  output logic areset
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;  // 8 ns period
  end

  initial begin
    areset = 1'b1;
    repeat (4) @(posedge aclk);
    areset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/tb_axi_mem.sv ====
`default_nettype none

module tb_axi_mem;

  timeunit 1ns;
  timeprecision 100ps;

  import axi_mem_pkg::*;

  // limit from about 220 transactions at worst wait plus stall plus handshakes
  localparam int n_trans = 220;
  localparam int cycle_limit = n_trans * (15 + 12 + 12) + 500;

  logic aclk, areset;
  logic [addr_w-1:0] if_araddr, ls_araddr, ls_awaddr;
  logic if_arvalid, if_arready, if_rvalid, if_rready;
  logic ls_arvalid, ls_arready, ls_rvalid, ls_rready;
  logic [data_w-1:0] if_rdata, ls_rdata, ls_wdata;
  axi_resp_e if_rresp, ls_rresp, ls_bresp;
  logic ls_awvalid, ls_awready, ls_wvalid, ls_wready, ls_bvalid, ls_bready;
  logic [strb_w-1:0] ls_wstrb;
  logic cfg_wr;
  cfg_reg_e cfg_sel;
  logic [wait_w-1:0] cfg_wdata;

  logic [data_w-1:0] ref_mem [mem_words];
  logic [33:0] if_exp_q[$];
  logic [33:0] ls_exp_q[$];
  axi_resp_e b_exp_q[$];
  logic [31:0] lcg_state = 32'd80931;
  int rd_wait_m = 0;
  int wr_wait_m = 0;
  logic prio_ls_m = 1'b0;  // fetch wins first tie
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int idx_tab [24];

  tb_clock_gen i_clk (.aclk(aclk), .areset(areset));

  axi_mem_top i_dut (.*);

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = nw[8*b +: 8];
    end
    return res;
  endfunction

  function automatic axi_resp_e resp_for(input logic [31:0] addr);
    if (addr >= mem_base && addr < mem_base + 32'(4 * mem_words)) return resp_okay;
    return resp_decerr;
  endfunction

  function automatic int idx_of(input logic [31:0] addr);
    return int'((addr - mem_base) >> 2);
  endfunction

  function automatic logic [31:0] addr_of(input int idx);
    return mem_base + 32'(idx * 4);
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic read_word(input bit port, input logic [31:0] addr, input bit lat_chk,
                           input int hold);
    int lat;
    axi_resp_e er;
    logic [31:0] ed;
    logic [31:0] held;
    er = resp_for(addr);
    ed = (er == resp_okay) ? ref_mem[idx_of(addr)] : '0;
    if (port) ls_exp_q.push_back({er, ed});
    else if_exp_q.push_back({er, ed});
    @(posedge aclk);
    if (port) begin
      ls_araddr <= addr;
      ls_arvalid <= 1'b1;
      ls_rready <= (hold == 0);
    end else begin
      if_araddr <= addr;
      if_arvalid <= 1'b1;
      if_rready <= (hold == 0);
    end
    do @(negedge aclk); while (!(port ? ls_arready : if_arready));
    @(posedge aclk);
    if (port) ls_arvalid <= 1'b0;
    else if_arvalid <= 1'b0;
    // edges from the ar handshake to rvalid
    lat = 0;
    @(negedge aclk);
    while (!(port ? ls_rvalid : if_rvalid)) begin
      @(negedge aclk);
      lat++;
    end
    if (lat_chk) check("read latency", lat, rd_wait_m + 2);
    if (hold > 0) begin
      held = port ? ls_rdata : if_rdata;
      repeat (hold) begin
        @(negedge aclk);
        check("rvalid held", port ? ls_rvalid : if_rvalid, 1);
        check("rdata held", port ? ls_rdata : if_rdata, held);
        check("arready while busy", {if_arready, ls_arready}, 0);
      end
      @(posedge aclk);
      if (port) ls_rready <= 1'b1;
      else if_rready <= 1'b1;
      @(negedge aclk);
    end
    @(posedge aclk);  // r handshake
    if (port) ls_rready <= 1'b0;
    else if_rready <= 1'b0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input bit w_late, input int hold);
    int lat;
    bit aw_ok, w_ok, aw_hit, w_hit;
    axi_resp_e er;
    er = resp_for(addr);
    b_exp_q.push_back(er);
    if (er == resp_okay) begin
      ref_mem[idx_of(addr)] = merge_bytes(ref_mem[idx_of(addr)], data, strb);
    end
    @(posedge aclk);
    ls_awaddr <= addr;
    ls_awvalid <= 1'b1;
    ls_wdata <= data;
    ls_wstrb <= strb;
    ls_wvalid <= !w_late;
    ls_bready <= (hold == 0);
    aw_ok = 0;
    w_ok = 0;
    while (!(aw_ok && w_ok)) begin
      @(negedge aclk);
      aw_hit = ls_awvalid && ls_awready;
      w_hit = ls_wvalid && ls_wready;
      @(posedge aclk);
      if (aw_hit) begin
        aw_ok = 1;
        ls_awvalid <= 1'b0;
      end
      if (w_hit) begin
        w_ok = 1;
        ls_wvalid <= 1'b0;
      end else if (!w_ok) begin
        ls_wvalid <= 1'b1;  // late w goes up now
      end
    end
    lat = 0;
    @(negedge aclk);
    while (!ls_bvalid) begin
      @(negedge aclk);
      lat++;
    end
    check("write latency", lat, wr_wait_m + 1);
    if (hold > 0) begin
      repeat (hold) begin
        @(negedge aclk);
        check("bvalid held", ls_bvalid, 1);
        check("bresp held", ls_bresp, er);
        check("awready wready while busy", {ls_awready, ls_wready}, 0);
      end
      @(posedge aclk);
      ls_bready <= 1'b1;
      @(negedge aclk);
    end
    @(posedge aclk);
    ls_bready <= 1'b0;
  endtask

  task automatic set_waits(input int rw, input int ww);
    @(posedge aclk);
    cfg_wr <= 1'b1;
    cfg_sel <= cfg_rd_wait;
    cfg_wdata <= wait_w'(rw);
    @(posedge aclk);
    cfg_sel <= cfg_wr_wait;
    cfg_wdata <= wait_w'(ww);
    @(posedge aclk);
    cfg_wr <= 1'b0;
    rd_wait_m = rw;
    wr_wait_m = ww;
  endtask

  // compares every handshake against the model
  always @(negedge aclk) begin
    logic [33:0] e;
    if (!areset) begin
      if (if_arvalid && ls_arvalid && (if_arready || ls_arready))
        check("tie grant to ls", ls_arready, prio_ls_m);
      if (if_arvalid && if_arready) prio_ls_m = 1'b1;
      else if (ls_arvalid && ls_arready) prio_ls_m = 1'b0;
      if (if_rvalid && if_rready) begin
        if (if_exp_q.size() == 0) begin
          errors++;
          $display("unexpected read response on the fetch port at %0d ns", $time);
        end else begin
          e = if_exp_q.pop_front();
          check("if rdata", if_rdata, e[31:0]);
          check("if rresp", if_rresp, e[33:32]);
        end
      end
      if (ls_rvalid && ls_rready) begin
        if (ls_exp_q.size() == 0) begin
          errors++;
          $display("unexpected read response on the load/store port at %0d ns", $time);
        end else begin
          e = ls_exp_q.pop_front();
          check("ls rdata", ls_rdata, e[31:0]);
          check("ls rresp", ls_rresp, e[33:32]);
        end
      end
      if (ls_bvalid && ls_bready) begin
        if (b_exp_q.size() == 0) begin
          errors++;
          $display("unexpected write response at %0d ns", $time);
        end else begin
          check("bresp", ls_bresp, b_exp_q.pop_front());
        end
      end
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    int a;
    int pw [4][2];
    pw = '{'{0, 0}, '{3, 1}, '{15, 15}, '{1, 7}};
    if_araddr = '0;
    if_arvalid = 1'b0;
    if_rready = 1'b0;
    ls_araddr = '0;
    ls_arvalid = 1'b0;
    ls_rready = 1'b0;
    ls_awaddr = '0;
    ls_awvalid = 1'b0;
    ls_wdata = '0;
    ls_wstrb = '0;
    ls_wvalid = 1'b0;
    ls_bready = 1'b0;
    cfg_wr = 1'b0;
    cfg_sel = cfg_rd_wait;
    cfg_wdata = '0;
    @(negedge aclk);
    while (areset) @(negedge aclk);
    check("ready or valid right after reset",
          {if_arready, ls_arready, ls_awready, ls_wready, if_rvalid, ls_rvalid, ls_bvalid}, 0);
    @(negedge aclk);
    check("write readies one cycle after reset", {ls_awready, ls_wready}, 2'b11);
    // fill a set of words with a pattern of the whole address
    for (int i = 0; i < 24; i++) begin
      idx_tab[i] = int'(rand_next() % mem_words);
      a = addr_of(idx_tab[i]);
      write_word(a, a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1, 4'hf, 0, 0);
    end
    // tied requests where fetch wins the first
    for (int i = 0; i < 4; i++) begin
      fork
        read_word(0, addr_of(idx_tab[i]), 0, 0);
        read_word(1, addr_of(idx_tab[i + 4]), 0, 0);
      join
      if (i == 1) read_word(0, addr_of(idx_tab[i]), 1, 0);  // flips next tie
    end
    for (int i = 0; i < 40; i++) begin
      a = addr_of(idx_tab[rand_next() % 24]);
      write_word(a, rand_next(), rand_next() % 16, rand_next() % 2, 0);
      read_word(1, a, 1, 0);
    end
    for (int i = 0; i < 30; i++) read_word(0, addr_of(idx_tab[rand_next() % 24]), 1, 0);
    foreach (pw[p]) begin
      set_waits(pw[p][0], pw[p][1]);
      for (int i = 0; i < 3; i++) begin
        a = addr_of(idx_tab[rand_next() % 24]);
        write_word(a, rand_next(), rand_next() % 16, rand_next() % 2, 0);
        read_word(i % 2, a, 1, 0);
      end
    end
    set_waits(2, 2);
    // words that the bad addresses below alias to
    write_word(addr_of(0), rand_next(), 4'hf, 0, 0);
    write_word(addr_of(mem_words - 1), rand_next(), 4'hf, 0, 0);
    // outside the window
    write_word(mem_base - 4, rand_next(), 4'hf, 0, 0);
    write_word(mem_base + 4 * mem_words, rand_next(), 4'hf, 1, 0);
    read_word(1, mem_base - 4, 1, 0);
    read_word(0, 32'h0000_0100, 1, 0);
    read_word(1, mem_base + 4 * mem_words, 1, 0);
    read_word(0, addr_of(0), 1, 0);
    read_word(1, addr_of(mem_words - 1), 1, 0);
    for (int i = 0; i < 24; i++) read_word(i % 2, addr_of(idx_tab[i]), 1, 0);
    // back-pressure on r and b
    for (int i = 0; i < 10; i++) begin
      a = addr_of(idx_tab[rand_next() % 24]);
      write_word(a, rand_next(), rand_next() % 16, 0, 1 + int'(rand_next() % 12));
      read_word(i % 2, a, 1, 1 + int'(rand_next() % 12));
    end
    repeat (4) @(posedge aclk);
    if (if_exp_q.size() != 0 || ls_exp_q.size() != 0 || b_exp_q.size() != 0) begin
      errors++;
      $display("some expected responses never arrived");
    end
    $display("checks %0d errors %0d cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/axi_mem_pkg.sv
logic/mem_wait_cfg.sv
logic/sram_array.sv
logic/axi_sram.sv
logic/axi_read_arbiter.sv
logic/axi_mem_top.sv
bench/tb_clock_gen.sv
bench/tb_axi_mem.sv

// ==== run.sh ====
#!/bin/sh
# build and run the AXI-lite memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_axi_mem \
  -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/Vtb_axi_mem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
